// File: cpu4_pkg.sv
package cpu4_pkg;

  // Register and immediate form, LD/ADD/CP r,i
  typedef struct packed {
    logic [5:0] opcode;
    logic [1:0] sel;
    logic [3:0] imm;
  } r_fmt_t;

  // Index compare form, CP XH/XL/YH/YL,i
  typedef struct packed {
    logic [7:0] opcode;
    logic [3:0] imm;
  } idx_fmt_t;

  // Byte immediate form, LD X,e and LD Y,e
  typedef struct packed {
    logic [3:0] opcode;
    logic [7:0] imm;
  } e_fmt_t;

  typedef union packed {
    r_fmt_t   r_fmt;
    idx_fmt_t idx_fmt;
    e_fmt_t   e_fmt;
  } inst_t;

  typedef enum logic [2:0] {
    OP_LD_R,
    OP_ADD_R,
    OP_CP_R,
    OP_CP_IDX,
    OP_LD_X,
    OP_LD_Y,
    OP_NOP
  } op_t;

  // First four follow the r selector encoding
  typedef enum logic [2:0] {
    DEST_A,
    DEST_B,
    DEST_MX,
    DEST_MY,
    DEST_X,
    DEST_Y,
    DEST_NONE
  } dest_t;

  localparam logic [5:0] OPC_LD_R  = 6'b111000;
  localparam logic [5:0] OPC_ADD_R = 6'b110000;
  localparam logic [5:0] OPC_CP_R  = 6'b110111;

  localparam logic [7:0] OPC_CP_XH = 8'hA4;
  localparam logic [7:0] OPC_CP_XL = 8'hA5;
  localparam logic [7:0] OPC_CP_YH = 8'hA6;
  localparam logic [7:0] OPC_CP_YL = 8'hA7;

  localparam logic [3:0] OPC_LD_X = 4'hB;
  localparam logic [3:0] OPC_LD_Y = 4'h8;

endpackage

// File: cpu4_decode.sv
module cpu4_decode (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              inst_valid,
  input  cpu4_pkg::inst_t   inst,
  output logic              inst_ready,
  output logic              dec_valid,
  input  logic              dec_ready,
  output cpu4_pkg::op_t     dec_op,
  output logic [1:0]        dec_sel,
  output logic [7:0]        dec_imm
);
  import cpu4_pkg::*;

  logic       run_q;
  logic       take;
  op_t        nxt_op;
  logic [1:0] nxt_sel;
  logic [7:0] nxt_imm;

  // Held off for the first cycle out of reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  assign inst_ready = run_q && (!dec_valid || dec_ready);
  assign take       = inst_valid && inst_ready;

  always_comb begin
    nxt_op  = OP_NOP;
    nxt_sel = inst.r_fmt.sel;
    nxt_imm = {4'h0, inst.r_fmt.imm};
    if (inst.e_fmt.opcode == OPC_LD_X) begin
      nxt_op  = OP_LD_X;
      nxt_imm = inst.e_fmt.imm;
    end else if (inst.e_fmt.opcode == OPC_LD_Y) begin
      nxt_op  = OP_LD_Y;
      nxt_imm = inst.e_fmt.imm;
    end else begin
      case (inst.idx_fmt.opcode)
        OPC_CP_XH: nxt_op = OP_CP_IDX;
        OPC_CP_XL: nxt_op = OP_CP_IDX;
        OPC_CP_YH: nxt_op = OP_CP_IDX;
        OPC_CP_YL: nxt_op = OP_CP_IDX;
        default: begin
          case (inst.r_fmt.opcode)
            OPC_LD_R:  nxt_op = OP_LD_R;
            OPC_ADD_R: nxt_op = OP_ADD_R;
            OPC_CP_R:  nxt_op = OP_CP_R;
            default:   nxt_op = OP_NOP;
          endcase
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else if (take) begin
      dec_valid <= 1'b1;
    end else if (dec_ready) begin
      dec_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      dec_op  <= nxt_op;
      dec_sel <= nxt_sel;
      dec_imm <= nxt_imm;
    end
  end

endmodule

// File: cpu4_execute.sv
module cpu4_execute #(
  parameter int RAM_AW = 8
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              dec_valid,
  output logic              dec_ready,
  input  cpu4_pkg::op_t     dec_op,
  input  logic [1:0]        dec_sel,
  input  logic [7:0]        dec_imm,
  output logic              ex_valid,
  input  logic              ex_ready,
  output cpu4_pkg::dest_t   ex_dest,
  output logic [7:0]        ex_data,
  output logic              ex_flag_we,
  output logic              ex_carry,
  output logic              ex_zero
);
  import cpu4_pkg::*;

  logic [3:0] a_q, b_q;
  logic [7:0] x_q, y_q;
  logic [3:0] ram [2**RAM_AW];

  logic              take;
  logic [RAM_AW-1:0] mx_addr, my_addr;
  logic [3:0]        opnd, idx_nib, cmp_src, wr_nib;
  logic [4:0]        sum;
  logic              reg_we;
  dest_t             nxt_dest;
  logic [7:0]        nxt_data;
  logic              nxt_we, nxt_carry, nxt_zero;

  assign dec_ready = !ex_valid || ex_ready;
  assign take      = dec_valid && dec_ready;
  assign mx_addr   = x_q[RAM_AW-1:0];
  assign my_addr   = y_q[RAM_AW-1:0];

  always_comb begin
    case (dec_sel)
      2'd0:    opnd = a_q;
      2'd1:    opnd = b_q;
      2'd2:    opnd = ram[mx_addr];
      default: opnd = ram[my_addr];
    endcase
    case (dec_sel)
      2'd0:    idx_nib = x_q[7:4];
      2'd1:    idx_nib = x_q[3:0];
      2'd2:    idx_nib = y_q[7:4];
      default: idx_nib = y_q[3:0];
    endcase
    cmp_src = (dec_op == OP_CP_IDX) ? idx_nib : opnd;
    sum     = {1'b0, opnd} + {1'b0, dec_imm[3:0]};
    wr_nib  = (dec_op == OP_ADD_R) ? sum[3:0] : dec_imm[3:0];
    reg_we  = take && (dec_op == OP_LD_R || dec_op == OP_ADD_R);

    nxt_dest  = DEST_NONE;
    nxt_data  = 8'h00;
    nxt_we    = 1'b0;
    nxt_carry = 1'b0;
    nxt_zero  = 1'b0;
    case (dec_op)
      OP_LD_R: begin
        nxt_dest = dest_t'({1'b0, dec_sel});
        nxt_data = {4'h0, wr_nib};
      end
      OP_ADD_R: begin
        nxt_dest  = dest_t'({1'b0, dec_sel});
        nxt_data  = {4'h0, wr_nib};
        nxt_we    = 1'b1;
        nxt_carry = sum[4];
        nxt_zero  = (sum[3:0] == 4'h0);
      end
      OP_CP_R, OP_CP_IDX: begin
        nxt_data  = {4'h0, cmp_src};
        nxt_we    = 1'b1;
        nxt_carry = (cmp_src < dec_imm[3:0]); // Borrow
        nxt_zero  = (cmp_src == dec_imm[3:0]);
      end
      OP_LD_X: begin
        nxt_dest = DEST_X;
        nxt_data = dec_imm;
      end
      OP_LD_Y: begin
        nxt_dest = DEST_Y;
        nxt_data = dec_imm;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      a_q <= 4'h0;
      b_q <= 4'h0;
      x_q <= 8'h00;
      y_q <= 8'h00;
    end else begin
      if (reg_we && dec_sel == 2'd0) a_q <= wr_nib;
      if (reg_we && dec_sel == 2'd1) b_q <= wr_nib;
      if (take && dec_op == OP_LD_X) x_q <= dec_imm;
      if (take && dec_op == OP_LD_Y) y_q <= dec_imm;
    end
  end

  // MX and MY writes land in RAM
  always_ff @(posedge clk) begin
    if (reg_we && dec_sel == 2'd2) ram[mx_addr] <= wr_nib;
    if (reg_we && dec_sel == 2'd3) ram[my_addr] <= wr_nib;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
    end else if (take) begin
      ex_valid <= 1'b1;
    end else if (ex_ready) begin
      ex_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      ex_dest    <= nxt_dest;
      ex_data    <= nxt_data;
      ex_flag_we <= nxt_we;
      ex_carry   <= nxt_carry;
      ex_zero    <= nxt_zero;
    end
  end

endmodule

// File: cpu4_result.sv
module cpu4_result (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              ex_valid,
  output logic              ex_ready,
  input  cpu4_pkg::dest_t   ex_dest,
  input  logic [7:0]        ex_data,
  input  logic              ex_flag_we,
  input  logic              ex_carry,
  input  logic              ex_zero,
  output logic              res_valid,
  input  logic              res_ready,
  output cpu4_pkg::dest_t   res_dest,
  output logic [7:0]        res_data,
  output logic              res_carry,
  output logic              res_zero
);

  logic take;

  assign ex_ready = !res_valid || res_ready;
  assign take     = ex_valid && ex_ready;

  // Flags only move as a record is loaded, so the flag
  // register doubles as the record's flag fields
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
      res_carry <= 1'b0;
      res_zero  <= 1'b0;
    end else begin
      if (take) begin
        res_valid <= 1'b1;
      end else if (res_ready) begin
        res_valid <= 1'b0;
      end
      if (take && ex_flag_we) begin
        res_carry <= ex_carry;
        res_zero  <= ex_zero;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      res_dest <= ex_dest;
      res_data <= ex_data;
    end
  end

endmodule

// File: cpu4_core.sv
module cpu4_core #(
  parameter int RAM_AW = 8
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              inst_valid,
  output logic              inst_ready,
  input  cpu4_pkg::inst_t   inst,
  output logic              res_valid,
  input  logic              res_ready,
  output cpu4_pkg::dest_t   res_dest,
  output logic [7:0]        res_data,
  output logic              res_carry,
  output logic              res_zero
);
  import cpu4_pkg::*;

  // Decode to execute
  logic       dec_valid, dec_ready;
  op_t        dec_op;
  logic [1:0] dec_sel;
  logic [7:0] dec_imm;

  // Execute to result
  logic       ex_valid, ex_ready;
  dest_t      ex_dest;
  logic [7:0] ex_data;
  logic       ex_flag_we, ex_carry, ex_zero;

  cpu4_decode u_decode (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_ready (inst_ready),
    .dec_valid  (dec_valid),
    .dec_ready  (dec_ready),
    .dec_op     (dec_op),
    .dec_sel    (dec_sel),
    .dec_imm    (dec_imm)
  );

  cpu4_execute #(.RAM_AW(RAM_AW)) u_execute (
    .clk        (clk),
    .arst_n     (arst_n),
    .dec_valid  (dec_valid),
    .dec_ready  (dec_ready),
    .dec_op     (dec_op),
    .dec_sel    (dec_sel),
    .dec_imm    (dec_imm),
    .ex_valid   (ex_valid),
    .ex_ready   (ex_ready),
    .ex_dest    (ex_dest),
    .ex_data    (ex_data),
    .ex_flag_we (ex_flag_we),
    .ex_carry   (ex_carry),
    .ex_zero    (ex_zero)
  );

  cpu4_result u_result (
    .clk        (clk),
    .arst_n     (arst_n),
    .ex_valid   (ex_valid),
    .ex_ready   (ex_ready),
    .ex_dest    (ex_dest),
    .ex_data    (ex_data),
    .ex_flag_we (ex_flag_we),
    .ex_carry   (ex_carry),
    .ex_zero    (ex_zero),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res_dest   (res_dest),
    .res_data   (res_data),
    .res_carry  (res_carry),
    .res_zero   (res_zero)
  );

endmodule

// File: tb_clock.sv
module tb_clock (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Release just after the 8th rising edge
  initial begin
    arst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1 arst_n = 1'b1;
  end

endmodule

// File: cpu4_core_tb.sv
module cpu4_core_tb;
  import cpu4_pkg::*;

  localparam int RAM_AW  = 8;
  localparam int N_TESTS = 6;

  logic       clk;
  logic       arst_n;
  logic       inst_valid;
  logic       inst_ready;
  inst_t      inst;
  logic       res_valid;
  logic       res_ready;
  dest_t      res_dest;
  logic [7:0] res_data;
  logic       res_carry;
  logic       res_zero;

  logic [31:0] lfsr = 32'h9894_ea25;
  logic        stall_on;

  // Reference model state
  logic [3:0] m_a, m_b;
  logic [7:0] m_x, m_y;
  logic       m_c, m_z;
  logic [3:0] m_ram [2**RAM_AW];
  logic       m_known [2**RAM_AW];

  logic [11:0] prog [$];
  dest_t       exp_dest [$];
  logic [7:0]  exp_data [$];
  logic        exp_carry [$];
  logic        exp_zero [$];

  int    test_first [N_TESTS];
  int    test_last [N_TESTS];
  string test_name [N_TESTS] = '{"loads", "cp_index", "cp_reg", "add_wrap", "unknown_op",
                                 "random_stall"};
  int    total_insts = 0;
  int    rec_count = 0;
  int    errors = 0;

  tb_clock u_clock (
    .clk    (clk),
    .arst_n (arst_n)
  );

  cpu4_core #(.RAM_AW(RAM_AW)) UUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .inst       (inst),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res_dest   (res_dest),
    .res_data   (res_data),
    .res_carry  (res_carry),
    .res_zero   (res_zero)
  );

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      v = (v << 1) | int'(lfsr_bit());
    end
    return v;
  endfunction

  function automatic logic [11:0] enc_r(input logic [5:0] opc, input logic [1:0] r,
                                        input logic [3:0] i);
    return {opc, r, i};
  endfunction

  function automatic logic [11:0] enc_idx(input logic [1:0] h, input logic [3:0] i);
    logic [7:0] opc;
    opc = OPC_CP_XH | {6'd0, h}; // XH, XL, YH, YL
    return {opc, i};
  endfunction

  function automatic dest_t reg_dest(input logic [1:0] r);
    case (r)
      2'd0:    return DEST_A;
      2'd1:    return DEST_B;
      2'd2:    return DEST_MX;
      default: return DEST_MY;
    endcase
  endfunction

  function automatic logic [3:0] read_reg(input logic [1:0] r);
    case (r)
      2'd0:    return m_a;
      2'd1:    return m_b;
      2'd2:    return m_ram[m_x[RAM_AW-1:0]];
      default: return m_ram[m_y[RAM_AW-1:0]];
    endcase
  endfunction

  function automatic void write_reg(input logic [1:0] r, input logic [3:0] v);
    case (r)
      2'd0: m_a = v;
      2'd1: m_b = v;
      2'd2: begin
        m_ram[m_x[RAM_AW-1:0]]   = v;
        m_known[m_x[RAM_AW-1:0]] = 1'b1;
      end
      default: begin
        m_ram[m_y[RAM_AW-1:0]]   = v;
        m_known[m_y[RAM_AW-1:0]] = 1'b1;
      end
    endcase
  endfunction

  // Applies one instruction to the model and queues its record
  function automatic void model_step(input logic [11:0] w);
    logic [1:0] r;
    logic [3:0] i;
    logic [3:0] opnd;
    logic [4:0] s;
    dest_t      d;
    logic [7:0] data;
    r    = w[5:4];
    i    = w[3:0];
    d    = DEST_NONE;
    data = 8'h00;
    if (w[11:8] == OPC_LD_X) begin
      m_x  = w[7:0];
      d    = DEST_X;
      data = w[7:0];
    end else if (w[11:8] == OPC_LD_Y) begin
      m_y  = w[7:0];
      d    = DEST_Y;
      data = w[7:0];
    end else if (w[11:4] >= OPC_CP_XH && w[11:4] <= OPC_CP_YL) begin
      case (r)
        2'd0:    opnd = m_x[7:4];
        2'd1:    opnd = m_x[3:0];
        2'd2:    opnd = m_y[7:4];
        default: opnd = m_y[3:0];
      endcase
      data = {4'h0, opnd};
      m_c  = (opnd < i);
      m_z  = (opnd == i);
    end else if (w[11:6] == OPC_LD_R) begin
      write_reg(r, i);
      d    = reg_dest(r);
      data = {4'h0, i};
    end else if (w[11:6] == OPC_ADD_R) begin
      s = {1'b0, read_reg(r)} + {1'b0, i};
      write_reg(r, s[3:0]);
      d    = reg_dest(r);
      data = {4'h0, s[3:0]};
      m_c  = s[4];
      m_z  = (s[3:0] == 4'h0);
    end else if (w[11:6] == OPC_CP_R) begin
      opnd = read_reg(r);
      data = {4'h0, opnd};
      m_c  = (opnd < i);
      m_z  = (opnd == i);
    end
    exp_dest.push_back(d);
    exp_data.push_back(data);
    exp_carry.push_back(m_c);
    exp_zero.push_back(m_z);
  endfunction

  function automatic void emit(input logic [11:0] w);
    prog.push_back(w);
    model_step(w);
  endfunction

  task automatic build_loads();
    emit(enc_r(OPC_CP_R, 2'd0, 4'hF)); // Sets carry before the loads
    emit(enc_r(OPC_LD_R, 2'd0, 4'h5));
    emit(enc_r(OPC_LD_R, 2'd1, 4'hA));
    emit({OPC_LD_X, 8'h3C});
    emit({OPC_LD_Y, 8'hC5});
    emit(enc_r(OPC_LD_R, 2'd2, 4'h7));
    emit(enc_r(OPC_LD_R, 2'd3, 4'h9));
    for (int r = 0; r < 4; r++) begin
      emit(enc_r(OPC_CP_R, r[1:0], 4'h0));
      emit(enc_idx(r[1:0], 4'h0));
    end
  endtask

  task automatic build_cp_index();
    logic [15:0] nibs;
    logic [3:0]  n;
    nibs = 16'h5A3C;
    emit({OPC_LD_X, nibs[15:8]});
    emit({OPC_LD_Y, nibs[7:0]});
    for (int h = 0; h < 4; h++) begin
      n = nibs[15 - 4 * h -: 4];
      emit(enc_idx(h[1:0], n - 4'd1));
      emit(enc_idx(h[1:0], n));
      emit(enc_idx(h[1:0], n + 4'd1));
    end
  endtask

  task automatic build_cp_reg();
    logic [15:0] vals;
    logic [3:0]  v;
    vals = 16'h694B;
    emit({OPC_LD_X, 8'h10});
    emit({OPC_LD_Y, 8'h20});
    for (int r = 0; r < 4; r++) begin
      emit(enc_r(OPC_LD_R, r[1:0], vals[15 - 4 * r -: 4]));
    end
    for (int r = 0; r < 4; r++) begin
      v = vals[15 - 4 * r -: 4];
      emit(enc_r(OPC_CP_R, r[1:0], v - 4'd1));
      emit(enc_r(OPC_CP_R, r[1:0], v));
      emit(enc_r(OPC_CP_R, r[1:0], v + 4'd1));
    end
    emit(enc_r(OPC_CP_R, 2'd2, 4'h4)); // RAM cells still hold
    emit(enc_r(OPC_CP_R, 2'd3, 4'hB));
  endtask

  task automatic build_add();
    emit(enc_r(OPC_LD_R, 2'd0, 4'hF));
    emit(enc_r(OPC_ADD_R, 2'd0, 4'h1));
    emit(enc_r(OPC_CP_R, 2'd0, 4'h0));
    emit(enc_r(OPC_LD_R, 2'd1, 4'h7));
    emit(enc_r(OPC_ADD_R, 2'd1, 4'h8));
    emit(enc_r(OPC_CP_R, 2'd1, 4'hF));
    emit(enc_r(OPC_ADD_R, 2'd1, 4'h3));
    emit(enc_r(OPC_CP_R, 2'd1, 4'h2));
    emit({OPC_LD_X, 8'h40});
    emit(enc_r(OPC_LD_R, 2'd2, 4'h9));
    emit(enc_r(OPC_ADD_R, 2'd2, 4'h9));
    emit(enc_r(OPC_CP_R, 2'd2, 4'h2));
    emit({OPC_LD_Y, 8'h41});
    emit(enc_r(OPC_LD_R, 2'd3, 4'h0));
    emit(enc_r(OPC_ADD_R, 2'd3, 4'h0));
  endtask

  task automatic build_unknown();
    emit(enc_r(OPC_CP_R, 2'd1, 4'hF));
    emit(12'h000);
    emit(12'hF5A);
    emit(12'hA3C);
    emit(12'hA8F);
    emit(12'h9FF);
    emit(12'hD05);
    emit(12'hE45);
    emit(enc_r(OPC_CP_R, 2'd0, 4'h0));
    emit(12'h7FF);
  endtask

  task automatic build_random(input int n);
    int         kind;
    int         v;
    logic [1:0] r;
    logic [7:0] e;
    logic       cold;
    for (int k = 0; k < n; k++) begin
      kind = rand_bits(3);
      v    = rand_bits(2);
      r    = v[1:0];
      v    = rand_bits(8);
      e    = v[7:0];
      cold = (r == 2'd2 && !m_known[m_x[RAM_AW-1:0]]) ||
             (r == 2'd3 && !m_known[m_y[RAM_AW-1:0]]);
      if (cold && (kind == 1 || kind == 2)) kind = 0; // Seed the cell first
      case (kind)
        1:       emit(enc_r(OPC_ADD_R, r, e[3:0]));
        2:       emit(enc_r(OPC_CP_R, r, e[3:0]));
        3:       emit(enc_idx(r, e[3:0]));
        4:       emit({OPC_LD_X, e});
        5:       emit({OPC_LD_Y, e});
        6:       emit({4'hF, e});
        default: emit(enc_r(OPC_LD_R, r, e[3:0]));
      endcase
    end
  endtask

  // Entered and left at one time unit after a rising edge
  task automatic send_word(input logic [11:0] w);
    int   gap;
    logic done;
    gap = stall_on ? rand_bits(2) : 0;
    if (gap > 0) begin
      inst_valid = 1'b0;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
    inst_valid = 1'b1;
    inst       = w;
    done       = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = inst_ready;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_dest(input string name, input dest_t got, input dest_t exp);
    if (got !== exp) begin
      $display("Mismatch %s record %0d: got %h expected %h", name, rec_count, got, exp);
      errors++;
    end
  endtask

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s record %0d: got %h expected %h", name, rec_count, got, exp);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    if (arst_n && res_valid && res_ready) begin
      if (rec_count >= exp_dest.size()) begin
        $display("Unexpected extra record after %0d expected records", rec_count);
        errors++;
      end else begin
        check_dest("res_dest", res_dest, exp_dest[rec_count]);
        check_value("res_data", res_data, exp_data[rec_count]);
        check_value("res_carry", {7'd0, res_carry}, {7'd0, exp_carry[rec_count]});
        check_value("res_zero", {7'd0, res_zero}, {7'd0, exp_zero[rec_count]});
      end
      rec_count++;
    end
  end

  initial begin
    wait (total_insts > 0);
    repeat (total_insts * 20 + 20) @(posedge clk);
    $display("Timeout: only %0d of %0d records came back", rec_count, total_insts);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    int err_start;
    int tests_failed;
    inst_valid   = 1'b0;
    inst         = '0;
    res_ready    = 1'b0;
    stall_on     = 1'b0;
    tests_failed = 0;
    m_a = 4'h0;
    m_b = 4'h0;
    m_x = 8'h00;
    m_y = 8'h00;
    m_c = 1'b0;
    m_z = 1'b0;
    for (int k = 0; k < 2**RAM_AW; k++) begin
      m_known[k] = 1'b0;
    end

    for (int t = 0; t < N_TESTS; t++) begin
      test_first[t] = prog.size();
      case (t)
        0:       build_loads();
        1:       build_cp_index();
        2:       build_cp_reg();
        3:       build_add();
        4:       build_unknown();
        default: build_random(300);
      endcase
      test_last[t] = prog.size();
    end
    total_insts = prog.size();

    // Output back-pressure, one slot after the driver
    fork
      forever begin
        @(posedge clk);
        #2;
        res_ready = stall_on ? (rand_bits(2) != 0) : 1'b1;
      end
    join_none

    @(posedge arst_n);
    @(posedge clk);
    #1;
    for (int t = 0; t < N_TESTS; t++) begin
      stall_on  = (t == N_TESTS - 1);
      err_start = errors;
      for (int idx = test_first[t]; idx < test_last[t]; idx++) begin
        send_word(prog[idx]);
      end
      inst_valid = 1'b0;
      while (rec_count < test_last[t]) begin
        @(posedge clk);
        #1;
      end
      if (errors != err_start) tests_failed++;
      $display("Test %0d %s: %0d records, %0d errors, %s", t + 1, test_name[t],
               test_last[t] - test_first[t], errors - err_start,
               (errors == err_start) ? "passed" : "failed");
    end

    repeat (10) @(posedge clk); // Catch stray records
    $display("Tests passed %0d failed %0d, records %0d, errors %0d",
             N_TESTS - tests_failed, tests_failed, rec_count, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: cpu4_core.f
cpu4_pkg.sv
cpu4_decode.sv
cpu4_execute.sv
cpu4_result.sv
cpu4_core.sv
tb_clock.sv
cpu4_core_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the cpu4_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cpu4_core_tb -f cpu4_core.f -o sim_cpu4_core
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_cpu4_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
